// File: compile.f
hw/fpuPkg.sv
hw/fpOperandIf.sv
hw/fpDecode.sv
hw/fpRegFile.sv
hw/fpHazard.sv
hw/fpUnpack.sv
hw/fpCompare.sv
hw/fpSgnjClass.sv
hw/fpu.sv
dv/fpu_assert.sv
dv/fpuTb.sv

// File: dv/fpuInput.txt
// instr  src(statusFs on illegal)  loadData  kind(0 store,1 int,2 flags,3 illegal)  expected
// All hex, one instruction per line
00002087 00000000 3F800000 2 00000000
20109153 00000000 00000000 2 00000000
00202027 00000000 00000000 0 BF800000
F00001D3 7FA00000 00000000 2 00000000
A011A2D3 00000000 00000000 2 00000010
A01112D3 00000000 00000000 1 00000001
28118253 00000000 00000000 2 00000010
00402027 00000000 00000000 0 3F800000
E00212D3 00000000 00000000 1 00000040
E00192D3 00000000 00000000 1 00000100
E00182D3 00000000 00000000 1 7FA00000
FE0002D3 00000003 00000000 3 00000001
00102027 00000000 00000000 3 00000001

// File: dv/fpuTb.sv
/* FPU testbench */
module fpuTb;

  localparam int maxLines = 64;

  logic                 clk = 1'b0, rst = 1'b1;
  logic                 stallE, stallM, stallW, flushE, flushM, flushW;
  logic [1:0]           statusFs;
  logic [31:0]          instrD;
  fpuPkg::intWord_t     forwardedSrcAE, fIntResM;
  fpuPkg::fpWord_t      readDataW, fWriteDataM;
  logic                 fpuStallD, illegalFpuInstrD, fRegWriteM, fpLoadStoreM;
  fpuPkg::flags_t       setFflagsM;

  logic [31:0] vec [0:5*maxLines-1];  // Five words per line
  int nLines, nextLine, idxD, idxE, idxM, idxW;
  int checks, errors, stallRun, stallSeen, cycleCount, cycleLimit;

  fpu DUT (.clk, .rst, .stallE, .stallM, .stallW, .flushE, .flushM, .flushW,
    .statusFs, .instrD, .forwardedSrcAE, .readDataW, .fpuStallD, .illegalFpuInstrD,
    .fRegWriteM, .fpLoadStoreM, .fWriteDataM, .fIntResM, .setFflagsM);

  bind fpu fpu_assert fpuAssert (.clk, .rst, .fpuStallD, .fRegWriteM, .setFflagsM);

  always #10 clk = ~clk;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic checkFp(input string name, input fpuPkg::fpWord_t exp, act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t %s expected %h actual %h", $time, name, exp, act);
    end else $display("ok at %0t %s = %h", $time, name, act);
  endtask

  task automatic checkInt(input string name, input fpuPkg::intWord_t exp, act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t %s expected %h actual %h", $time, name, exp, act);
    end else $display("ok at %0t %s = %h", $time, name, act);
  endtask

  task automatic checkFlags(input string name, input fpuPkg::flags_t exp, act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t %s expected %b actual %b", $time, name, exp, act);
    end else $display("ok at %0t %s = %b", $time, name, act);
  endtask

  task automatic checkBit(input string name, input logic exp, act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t %s expected %b actual %b", $time, name, exp, act);
    end else $display("ok at %0t %s = %b", $time, name, act);
  endtask

  // flw, fsgnj*, fmin/fmax and fmv.w.x write an FP register
  function automatic logic writesFpReg(input logic [31:0] instr);
    logic [6:0] op;
    logic [6:0] f7;
    op = instr[6:0];
    f7 = instr[fpuPkg::funct7Lsb +: 7];
    if (op == fpuPkg::opLoadFp) return 1'b1;
    if (op != fpuPkg::opFp) return 1'b0;
    return (f7 == fpuPkg::funct7Sgnj) || (f7 == fpuPkg::funct7MinMax) ||
           (f7 == fpuPkg::funct7MvWx);
  endfunction

  // flw and fsw use the data ports
  function automatic logic accessesMemory(input logic [31:0] instr);
    return (instr[6:0] == fpuPkg::opLoadFp) || (instr[6:0] == fpuPkg::opStoreFp);
  endfunction

  // Expected value of the line now in M
  task automatic checkStageM(input int idx);
    logic legal;
    legal = (vec[5*idx+3] != 3);
    // Illegal lines leave a bubble
    checkBit("fRegWriteM", legal && writesFpReg(vec[5*idx]), fRegWriteM);
    checkBit("fpLoadStoreM", legal && accessesMemory(vec[5*idx]), fpLoadStoreM);
    case (vec[5*idx+3])
      0: checkFp("fWriteDataM", vec[5*idx+4], fWriteDataM);
      1: checkInt("fIntResM", vec[5*idx+4], fIntResM);
      2: checkFlags("setFflagsM", fpuPkg::flags_t'(vec[5*idx+4]), setFflagsM);
      default: ;  // Illegal lines are checked in D
    endcase
  endtask

  // Watchdog
  always @(posedge clk) begin
    if (!rst) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
        $display("run timed out after %0d cycles", cycleCount);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  initial begin
    {stallE, stallM, stallW, flushE, flushM, flushW} = '0;
    statusFs = 2'b11;
    instrD = 32'h0000_0013;  // Integer nop
    forwardedSrcAE = '0;
    readDataW = '0;
    {checks, errors, stallRun, stallSeen, cycleCount, nextLine} = '0;
    {idxD, idxE, idxM, idxW} = {-32'sd1, -32'sd1, -32'sd1, -32'sd1};
    cycleLimit = 1000;
    $readmemh("dv/fpuInput.txt", vec);
    nLines = 0;
    while (nLines < maxLines && vec[5*nLines] !== 'x) nLines++;
    cycleLimit = 4 * nLines + 40;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    do begin
      @(negedge clk);
      // Follow the pipeline, a flushed D leaves a bubble
      idxW = idxM;
      idxM = idxE;
      idxE = flushE ? -1 : idxD;
      if (idxM >= 0) checkStageM(idxM);
      forwardedSrcAE = (idxE >= 0) ? vec[5*idxE+1] : '0;
      readDataW      = (idxW >= 0) ? vec[5*idxW+2] : '0;
      if (!flushE) begin
        if (nextLine < nLines) begin
          idxD     = nextLine;
          instrD   = vec[5*idxD];
          statusFs = (vec[5*idxD+3] == 3) ? vec[5*idxD+1][1:0] : 2'b11;
          nextLine++;
        end else begin
          idxD     = -1;
          instrD   = 32'h0000_0013;
          statusFs = 2'b11;
        end
        #1;
        if (idxD >= 0)
          checkBit("illegalFpuInstrD", (vec[5*idxD+3] == 3) && vec[5*idxD+4][0],
                   illegalFpuInstrD);
      end else #1;
      // Hold D and bubble E on a load-use stall
      flushE = fpuStallD;
      stallRun = fpuStallD ? stallRun + 1 : 0;
      if (fpuStallD) stallSeen = 1;
      if (stallRun > 2) begin
        errors++;
        $display("load-use stall lasted more than two cycles at %0t", $time);
      end
    end while (nextLine < nLines || idxD >= 0 || idxE >= 0 || idxM >= 0 || idxW >= 0);
    if (!stallSeen) begin
      errors++;
      $display("no load-use stall was seen after the flw");
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: dv/fpu_assert.sv
/* FPU control assertions */
module fpu_assert (
  input logic                 clk,
  input logic                 rst,
  input logic                 fpuStallD,
  input logic                 fRegWriteM,
  input fpuPkg::flags_t       setFflagsM
);

  // Load-use stall never lasts three cycles
  stallLimit: assert property (@(posedge clk) disable iff (rst)
    (fpuStallD && $past(fpuStallD)) |-> !$past(fpuStallD, 2))
    else $error("fpuStallD high for three cycles");

  // Only NV can be raised by the kept instructions
  flagsNvOnly: assert property (@(posedge clk) disable iff (rst)
    setFflagsM[3:0] == 4'b0000)
    else $error("setFflagsM has DZ, OF, UF or NX set");

  // Control registers come out of reset cleared
  writeAfterReset: assert property (@(posedge clk) $fell(rst) |-> !fRegWriteM)
    else $error("fRegWriteM high right after reset");

endmodule

// File: hw/fpu.sv
/* Single-precision FPU top level */
module fpu (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallE, stallM, stallW,
  input  logic              flushE, flushM, flushW,
  input  logic [1:0]        statusFs,         // FPU enable from status
  input  logic [31:0]       instrD,
  input  fpuPkg::intWord_t  forwardedSrcAE,   // Integer source for fmv.w.x
  input  fpuPkg::fpWord_t   readDataW,        // Load data
  output logic              fpuStallD,
  output logic              illegalFpuInstrD,
  output logic              fRegWriteM,
  output logic              fpLoadStoreM,     // flw or fsw in M
  output fpuPkg::fpWord_t   fWriteDataM,      // Store data
  output fpuPkg::intWord_t  fIntResM,
  output fpuPkg::flags_t    setFflagsM
);

  fpuPkg::regAdr_t  adr1D, adr2D, adr1E, adr2E, rdE, rdM, rdW;
  logic             xEnD, yEnD, fRegWriteE, fRegWriteW, loadE, loadM;
  logic             cmpE, minmaxE, classE, mvxE;
  fpuPkg::resSel_t  resSelE, resSelW;
  fpuPkg::opCtrl_t  opCtrlE;
  fpuPkg::fwdSel_t  forwardXE, forwardYE;
  fpuPkg::fpWord_t  rd1D, rd2D, rd1E, rd2E;   // Register file reads
  fpuPkg::fpWord_t  xE, yE;                   // After forwarding
  fpuPkg::fpWord_t  cmpFpResE, sgnResE, fpResE, fpResM, fpResW, fResultW;
  fpuPkg::intWord_t classResE, cmpIntResE, fIntResE;
  logic             cmpNvE;
  fpuPkg::flags_t   flagsE;

  assign adr1D = instrD[fpuPkg::rs1Lsb +: 5];
  assign adr2D = instrD[fpuPkg::rs2Lsb +: 5];

  //////////////////////////////
  // Decode stage
  //////////////////////////////

  fpDecode decode (.clk, .rst, .instrD, .statusFs, .stallE, .stallM, .stallW,
    .flushE, .flushM, .flushW, .illegalFpuInstrD, .xEnD, .yEnD,
    .fRegWriteE, .fRegWriteM, .fRegWriteW, .loadE, .loadM, .resSelE, .resSelW,
    .opCtrlE, .cmpE, .minmaxE, .classE, .mvxE, .fpLoadStoreM,
    .rdE, .rdM, .rdW, .adr1E, .adr2E);

  fpRegFile regFile (.clk, .rst, .we(fRegWriteW), .adr1(adr1D), .adr2(adr2D),
    .wAdr(rdW), .wd(fResultW), .rd1(rd1D), .rd2(rd2D));

  always_ff @(posedge clk) begin  // D/E operands
    if (~stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
    end
  end

  //////////////////////////////
  // Execute stage
  //////////////////////////////

  fpHazard hazard (.adr1D, .adr2D, .xEnD, .yEnD, .adr1E, .adr2E, .rdE, .rdM, .rdW,
    .fRegWriteM, .fRegWriteW, .loadE, .loadM, .forwardXE, .forwardYE, .fpuStallD);

  always_comb begin
    case (forwardXE)
      fpuPkg::fwdM: xE = fpResM;
      fpuPkg::fwdW: xE = fResultW;
      default:      xE = rd1E;
    endcase
    case (forwardYE)
      fpuPkg::fwdM: yE = fpResM;
      fpuPkg::fwdW: yE = fResultW;
      default:      yE = rd2E;
    endcase
  end

  fpOperandIf xOp ();
  fpOperandIf yOp ();

  fpUnpack unpackX (.x(xE), .op(xOp.unpack));
  fpUnpack unpackY (.x(yE), .op(yOp.unpack));

  fpCompare compare (.x(xOp.reader), .y(yOp.reader), .opCtrl(opCtrlE), .minmax(minmaxE),
    .cmpFpRes(cmpFpResE), .cmpIntRes(cmpIntResE), .cmpNv(cmpNvE));

  fpSgnjClass sgnjClass (.x(xOp.reader), .y(yOp.reader), .opCtrl(opCtrlE),
    .sgnRes(sgnResE), .classRes(classResE));

  // Result muxes
  assign fpResE   = (resSelE == fpuPkg::resCmp) ? cmpFpResE :
                    (mvxE ? forwardedSrcAE : sgnResE);   // fmv.w.x moves the raw bits
  assign fIntResE = classE ? classResE : (mvxE ? xE : cmpIntResE);
  assign flagsE   = {cmpNvE & (cmpE | minmaxE), 4'b0000};  // Only NV can occur

  //////////////////////////////
  // E/M and M/W registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (~stallM) begin
      fIntResM    <= fIntResE;
      fWriteDataM <= yE;                  // fsw data is forwarded y
      if (fRegWriteE) fpResM <= fpResE;   // Hold when nothing writes
    end
  end

  always_ff @(posedge clk) begin
    if (rst | (flushM & ~stallM)) setFflagsM <= '0;
    else if (~stallM)             setFflagsM <= flagsE;
  end

  always_ff @(posedge clk) begin
    if (~stallW) fpResW <= fpResM;
  end

  // Writeback, load data or execute result
  assign fResultW = (resSelW == fpuPkg::resLoad) ? readDataW : fpResW;

endmodule

// File: hw/fpSgnjClass.sv
/* Sign injection and classify */
module fpSgnjClass (
  fpOperandIf.reader        x,
  fpOperandIf.reader        y,
  input  fpuPkg::opCtrl_t   opCtrl,
  output fpuPkg::fpWord_t   sgnRes,
  output fpuPkg::intWord_t  classRes
);

  logic       sgn;     // Injected sign
  logic       normal;
  logic [9:0] cls;     // One-hot class

  always_comb begin
    case (opCtrl[1:0])
      2'b00:   sgn = y.sign;           // fsgnj
      2'b01:   sgn = ~y.sign;          // fsgnjn
      default: sgn = x.sign ^ y.sign;  // fsgnjx
    endcase
  end

  assign sgnRes = {sgn, x.raw[fpuPkg::flen-2:0]};  // x magnitude kept

  assign normal = ~(x.nan | x.inf | x.zero | x.subnorm);

  // fclass bit order, -inf at bit 0 up to qNaN at bit 9
  assign cls = {x.nan & ~x.snan, x.snan,
                ~x.sign & x.inf, ~x.sign & normal, ~x.sign & x.subnorm, ~x.sign & x.zero,
                x.sign & x.zero, x.sign & x.subnorm, x.sign & normal, x.sign & x.inf};

  assign classRes = fpuPkg::intWord_t'(cls);

endmodule

// File: hw/fpCompare.sv
/* FP min/max and compare */
module fpCompare (
  fpOperandIf.reader        x,
  fpOperandIf.reader        y,
  input  fpuPkg::opCtrl_t   opCtrl,     // funct3
  input  logic              minmax,     // fmin/fmax, else feq/flt/fle
  output fpuPkg::fpWord_t   cmpFpRes,
  output fpuPkg::intWord_t  cmpIntRes,
  output logic              cmpNv
);

  logic [fpuPkg::ne+fpuPkg::nf:0] magX, magY;  // Exponent over significand
  logic anyNaN, anySNaN, bothZero;
  logic ltOrd;                                  // x below y, -0 below +0
  logic eq, lt, le;

  assign magX = {x.exp, x.man};
  assign magY = {y.exp, y.man};

  assign anyNaN   = x.nan | y.nan;
  assign anySNaN  = x.snan | y.snan;
  assign bothZero = x.zero & y.zero;

  always_comb begin
    if (x.sign != y.sign) ltOrd = x.sign;   // Negative one is smaller
    else if (x.sign)      ltOrd = magX > magY;
    else                  ltOrd = magX < magY;
  end

  // Signed zeros are equal here
  assign eq = (x.raw == y.raw) | bothZero;
  assign lt = ltOrd & ~bothZero;
  assign le = lt | eq;

  //////////////////////////////
  // Min/max
  //////////////////////////////

  always_comb begin
    if (x.nan & y.nan)  cmpFpRes = fpuPkg::canonicalNaN;
    else if (x.nan)     cmpFpRes = y.raw;            // Other operand wins
    else if (y.nan)     cmpFpRes = x.raw;
    else if (opCtrl[0]) cmpFpRes = ltOrd ? y.raw : x.raw;  // fmax
    else                cmpFpRes = ltOrd ? x.raw : y.raw;  // fmin
  end

  // feq/flt/fle, 0 on any NaN
  always_comb begin
    cmpIntRes = '0;
    if (!anyNaN) begin
      case (opCtrl)
        3'b010:  cmpIntRes[0] = eq;
        3'b001:  cmpIntRes[0] = lt;
        3'b000:  cmpIntRes[0] = le;
        default: cmpIntRes[0] = 1'b0;
      endcase
    end
  end

  // Only feq and min/max stay quiet on qNaN
  assign cmpNv = (minmax | (opCtrl == 3'b010)) ? anySNaN : anyNaN;

endmodule

// File: hw/fpUnpack.sv
/* Operand unpack and classify */
module fpUnpack (
  input  fpuPkg::fpWord_t   x,
  fpOperandIf.unpack        op
);

  logic expZero;   // Zero or subnormal
  logic expOnes;   // Inf or NaN
  logic fracZero;

  assign op.raw  = x;
  assign op.sign = x[fpuPkg::flen-1];
  assign op.exp  = x[fpuPkg::nf +: fpuPkg::ne];
  assign op.man  = {~expZero, x[fpuPkg::nf-1:0]};  // Hidden bit

  assign expZero  = ~|op.exp;
  assign expOnes  = &op.exp;
  assign fracZero = ~|x[fpuPkg::nf-1:0];

  // Classes
  assign op.zero    = expZero & fracZero;
  assign op.subnorm = expZero & ~fracZero;
  assign op.inf     = expOnes & fracZero;
  assign op.nan     = expOnes & ~fracZero;
  assign op.snan    = op.nan & ~x[fpuPkg::nf-1];  // Quiet bit is fraction MSB

endmodule

// File: hw/fpHazard.sv
/* FPU forwarding and load-use stall */
module fpHazard (
  input  fpuPkg::regAdr_t   adr1D, adr2D,
  input  logic              xEnD, yEnD,
  input  fpuPkg::regAdr_t   adr1E, adr2E,
  input  fpuPkg::regAdr_t   rdE, rdM, rdW,
  input  logic              fRegWriteM, fRegWriteW,
  input  logic              loadE, loadM,
  output fpuPkg::fwdSel_t   forwardXE, forwardYE,
  output logic              fpuStallD
);

  logic hitE, hitM;  // D source waits on a flw

  always_comb begin
    forwardXE = fpuPkg::fwdRf;
    forwardYE = fpuPkg::fwdRf;
    // M has priority, but load data only exists in W
    if (fRegWriteM & ~loadM & (rdM == adr1E)) forwardXE = fpuPkg::fwdM;
    else if (fRegWriteW & (rdW == adr1E))     forwardXE = fpuPkg::fwdW;
    if (fRegWriteM & ~loadM & (rdM == adr2E)) forwardYE = fpuPkg::fwdM;
    else if (fRegWriteW & (rdW == adr2E))     forwardYE = fpuPkg::fwdW;
  end

  assign hitE = loadE & ((xEnD & (adr1D == rdE)) | (yEnD & (adr2D == rdE)));
  assign hitM = loadM & ((xEnD & (adr1D == rdM)) | (yEnD & (adr2D == rdM)));

  assign fpuStallD = hitE | hitM;  // Two cycles at most

endmodule

// File: hw/fpRegFile.sv
/* FP register file */
module fpRegFile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,          // Write in W
  input  fpuPkg::regAdr_t   adr1, adr2,  // Read ports
  input  fpuPkg::regAdr_t   wAdr,
  input  fpuPkg::fpWord_t   wd,
  output fpuPkg::fpWord_t   rd1, rd2
);

  fpuPkg::fpWord_t rf [32];  // f0 is a normal register

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (we) begin
      rf[wAdr] <= wd;
    end
  end

  // Write-through so D sees the value retiring in W
  assign rd1 = (we && (adr1 == wAdr)) ? wd : rf[adr1];
  assign rd2 = (we && (adr2 == wAdr)) ? wd : rf[adr2];

endmodule

// File: hw/fpDecode.sv
/* FPU control decoder */
module fpDecode (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       instrD,
  input  logic [1:0]        statusFs,          // 0 means FPU off
  input  logic              stallE, stallM, stallW,
  input  logic              flushE, flushM, flushW,
  output logic              illegalFpuInstrD,
  output logic              xEnD, yEnD,        // Sources really read
  output logic              fRegWriteE, fRegWriteM, fRegWriteW,
  output logic              loadE, loadM,      // flw in flight
  output fpuPkg::resSel_t   resSelE, resSelW,
  output fpuPkg::opCtrl_t   opCtrlE,
  output logic              cmpE, minmaxE, classE, mvxE,
  output logic              fpLoadStoreM,
  output fpuPkg::regAdr_t   rdE, rdM, rdW,
  output fpuPkg::regAdr_t   adr1E, adr2E
);

  logic [6:0]        opD, funct7D;
  logic [2:0]        funct3D;
  fpuPkg::regAdr_t   rs2D, rdD, adr1D, adr2D;
  logic              validD, enD, fpInstrD;
  logic              useXD, useYD;
  logic              fRegWriteD, loadD, storeD;
  logic              cmpD, minmaxD, classD, mvxD;
  fpuPkg::resSel_t   resSelD, resSelM;
  logic              fpLoadStoreE;

  assign opD     = instrD[6:0];
  assign funct7D = instrD[fpuPkg::funct7Lsb +: 7];
  assign funct3D = instrD[fpuPkg::funct3Lsb +: 3];
  assign rs2D    = instrD[fpuPkg::rs2Lsb +: 5];
  assign rdD     = instrD[fpuPkg::rdLsb +: 5];
  assign adr1D   = instrD[fpuPkg::rs1Lsb +: 5];
  assign adr2D   = rs2D;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    // Bubble unless a legal encoding matches
    validD     = 1'b0;
    useXD      = 1'b0;
    useYD      = 1'b0;
    fRegWriteD = 1'b0;
    loadD      = 1'b0;
    storeD     = 1'b0;
    resSelD    = fpuPkg::resSgn;
    cmpD       = 1'b0;
    minmaxD    = 1'b0;
    classD     = 1'b0;
    mvxD       = 1'b0;
    case (opD)
      fpuPkg::opLoadFp: begin
        validD     = (funct3D == fpuPkg::funct3Word);
        fRegWriteD = 1'b1;
        loadD      = 1'b1;
        resSelD    = fpuPkg::resLoad;  // Data arrives in W
      end
      fpuPkg::opStoreFp: begin
        validD = (funct3D == fpuPkg::funct3Word);
        useYD  = 1'b1;                 // rs2 is the store data
        storeD = 1'b1;
      end
      fpuPkg::opFp: begin
        case (funct7D)
          fpuPkg::funct7Sgnj: begin
            validD     = (funct3D <= 3'd2);  // j, jn, jx
            useXD      = 1'b1;
            useYD      = 1'b1;
            fRegWriteD = 1'b1;
          end
          fpuPkg::funct7MinMax: begin
            validD     = (funct3D <= 3'd1);  // min, max
            useXD      = 1'b1;
            useYD      = 1'b1;
            fRegWriteD = 1'b1;
            resSelD    = fpuPkg::resCmp;
            minmaxD    = 1'b1;
          end
          fpuPkg::funct7Cmp: begin
            validD  = (funct3D <= 3'd2);     // le, lt, eq
            useXD   = 1'b1;
            useYD   = 1'b1;
            resSelD = fpuPkg::resInt;
            cmpD    = 1'b1;
          end
          fpuPkg::funct7ClassMvx: begin
            validD  = (rs2D == '0) && (funct3D <= 3'd1);
            useXD   = 1'b1;
            resSelD = fpuPkg::resInt;
            classD  = funct3D[0];            // fclass
            mvxD    = ~funct3D[0];           // fmv.x.w
          end
          fpuPkg::funct7MvWx: begin
            validD     = (rs2D == '0) && (funct3D == 3'd0);
            fRegWriteD = 1'b1;
            mvxD       = 1'b1;               // Integer source moves in
          end
          default: validD = 1'b0;
        endcase
      end
      default: validD = 1'b0;
    endcase
  end

  assign fpInstrD         = (opD == fpuPkg::opFp) | (opD == fpuPkg::opLoadFp) |
                            (opD == fpuPkg::opStoreFp);
  assign enD              = validD & (statusFs != 2'b00);
  assign illegalFpuInstrD = fpInstrD & ~enD;  // Bad encoding or FPU off
  assign xEnD             = useXD & enD;
  assign yEnD             = useYD & enD;

  //////////////////////////////
  // Control pipeline
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | (flushE & ~stallE)) begin  // Stall wins over flush
      {fRegWriteE, loadE, fpLoadStoreE, cmpE, minmaxE, classE, mvxE} <= '0;
      resSelE <= fpuPkg::resSgn;
      opCtrlE <= '0;
      {rdE, adr1E, adr2E} <= '0;
    end else if (~stallE) begin
      {fRegWriteE, loadE, fpLoadStoreE, cmpE, minmaxE, classE, mvxE} <=
        enD ? {fRegWriteD, loadD, loadD | storeD, cmpD, minmaxD, classD, mvxD} : 7'b0;
      resSelE <= resSelD;
      opCtrlE <= funct3D;
      {rdE, adr1E, adr2E} <= {rdD, adr1D, adr2D};
    end
  end

  always_ff @(posedge clk) begin
    if (rst | (flushM & ~stallM)) begin
      {fRegWriteM, loadM, fpLoadStoreM} <= '0;
      resSelM <= fpuPkg::resSgn;
      rdM     <= '0;
    end else if (~stallM) begin
      {fRegWriteM, loadM, fpLoadStoreM} <= {fRegWriteE, loadE, fpLoadStoreE};
      resSelM <= resSelE;
      rdM     <= rdE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst | (flushW & ~stallW)) begin
      fRegWriteW <= 1'b0;
      resSelW    <= fpuPkg::resSgn;
      rdW        <= '0;
    end else if (~stallW) begin
      fRegWriteW <= fRegWriteM;  // Register file write at end of W
      resSelW    <= resSelM;
      rdW        <= rdM;
    end
  end

endmodule

// File: hw/fpOperandIf.sv
/* Unpacked FP operand */
interface fpOperandIf;

  logic            sign;
  fpuPkg::exp_t    exp;      // Biased exponent
  fpuPkg::man_t    man;      // Hidden bit on top
  logic            nan;
  logic            snan;     // Quiet bit clear
  logic            zero;
  logic            inf;
  logic            subnorm;
  fpuPkg::fpWord_t raw;      // Word as read

  // Unpacker side
  modport unpack (output sign, exp, man, nan, snan, zero, inf, subnorm, raw);
  // Execute units, read only
  modport reader (input sign, exp, man, nan, snan, zero, inf, subnorm, raw);

endinterface

// File: hw/fpuPkg.sv
/* FPU shared definitions */
package fpuPkg;

  // Word and field widths
  localparam int flen = 32;  // FP register width
  localparam int xlen = 32;  // Integer register width
  localparam int ne   = 8;   // Exponent bits
  localparam int nf   = 23;  // Fraction bits

  typedef logic [flen-1:0] fpWord_t;   // FP register value
  typedef logic [xlen-1:0] intWord_t;  // Integer result or source
  typedef logic [ne-1:0]   exp_t;
  typedef logic [nf:0]     man_t;      // Significand with hidden bit
  typedef logic [4:0]      regAdr_t;
  typedef logic [2:0]      opCtrl_t;   // funct3 of the operation
  typedef logic [1:0]      resSel_t;
  typedef logic [1:0]      fwdSel_t;
  typedef logic [4:0]      flags_t;    // NV DZ OF UF NX

  // Result sources
  localparam resSel_t resSgn  = 2'b00;  // Sign inject or move in
  localparam resSel_t resCmp  = 2'b01;  // Min/max
  localparam resSel_t resInt  = 2'b10;  // Integer side only
  localparam resSel_t resLoad = 2'b11;  // Load data in W

  // Forward sources
  localparam fwdSel_t fwdRf = 2'b00;
  localparam fwdSel_t fwdM  = 2'b01;
  localparam fwdSel_t fwdW  = 2'b10;

  localparam fpWord_t canonicalNaN = 32'h7FC0_0000;

  // Opcodes
  localparam logic [6:0] opFp      = 7'b1010011;
  localparam logic [6:0] opLoadFp  = 7'b0000111;
  localparam logic [6:0] opStoreFp = 7'b0100111;

  // funct7 groups of OP-FP
  localparam logic [6:0] funct7Sgnj     = 7'b0010000;
  localparam logic [6:0] funct7MinMax   = 7'b0010100;
  localparam logic [6:0] funct7Cmp      = 7'b1010000;
  localparam logic [6:0] funct7ClassMvx = 7'b1110000;
  localparam logic [6:0] funct7MvWx     = 7'b1111000;
  localparam logic [2:0] funct3Word     = 3'b010;  // Width field of flw/fsw

  // Instruction field positions (LSB)
  localparam int rdLsb     = 7;
  localparam int funct3Lsb = 12;
  localparam int rs1Lsb    = 15;
  localparam int rs2Lsb    = 20;
  localparam int funct7Lsb = 25;

endpackage
